// File: design/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    // Opcodes
    localparam opcode_t OPCODE_RTYPE = 6'b000000;
    localparam opcode_t OPCODE_ADDI  = 6'b001000;
    localparam opcode_t OPCODE_LW    = 6'b100011;
    localparam opcode_t OPCODE_SW    = 6'b101011;
    localparam opcode_t OPCODE_HALT  = 6'b111111;

    // R-type funct codes
    localparam funct_t FUNCT_ADD = 6'b100000;
    localparam funct_t FUNCT_SUB = 6'b100010;
    localparam funct_t FUNCT_AND = 6'b100100;
    localparam funct_t FUNCT_OR  = 6'b100101;
    localparam funct_t FUNCT_SLT = 6'b101010;

    // Register field positions
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;

endpackage

// File: design/mips_core_pkg.sv
package mips_core_pkg;

    typedef logic [7:0] imem_addr_t;
    localparam int IMEM_DEPTH = 256;

    // Word index taken from byte address bits 9:2
    typedef logic [7:0] dmem_addr_t;
    localparam int DMEM_DEPTH = 256;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_NONE  = 2'd0;
    localparam fwd_sel_t FWD_EXMEM = 2'd1;
    localparam fwd_sel_t FWD_MEMWB = 2'd2;

endpackage

// File: design/mips_stage_if.sv
`timescale 1ns/1ps

interface id_ex_bus
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
();
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm_ext;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dst_reg;
    alu_op_t   alu_op;
    logic      alu_src;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      halt;

    modport src (output rs_data, rt_data, imm_ext, rs, rt, dst_reg, alu_op,
                 output alu_src, mem_read, mem_write, reg_write, halt);
    modport dst (input rs_data, rt_data, imm_ext, rs, rt, dst_reg, alu_op,
                 input alu_src, mem_read, mem_write, reg_write, halt);
endinterface

interface ex_mem_bus
    import mips_isa_pkg::*;
();
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t dst_reg;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      halt;

    modport src (output alu_result, store_data, dst_reg, mem_read, mem_write, reg_write, halt);
    modport dst (input alu_result, store_data, dst_reg, mem_read, mem_write, reg_write, halt);
endinterface

interface wb_bus
    import mips_isa_pkg::*;
();
    logic      reg_write;
    reg_addr_t dst_reg;
    word_t     data;
    logic      halt;

    modport src (output reg_write, dst_reg, data, halt);
    modport dst (input reg_write, dst_reg, data, halt);
endinterface

// File: design/stage_fetch.sv
`timescale 1ns/1ps

module stage_fetch
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_step,
    input  logic       i_hold,
    input  logic       i_imem_wr_en,
    input  imem_addr_t i_imem_wr_addr,
    input  word_t      i_imem_wr_data,
    output word_t      o_pc,
    output word_t      o_instr
);

    word_t      imem [IMEM_DEPTH];
    word_t      pc;
    word_t      if_id_instr;
    imem_addr_t fetch_addr;

    assign fetch_addr = pc[9:2];

    // Debug load port, active even while stepping is off
    always_ff @(posedge i_clk) begin
        if (i_imem_wr_en) begin
            imem[i_imem_wr_addr] <= i_imem_wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc          <= '0;
            if_id_instr <= '0;
        end else if (i_step && !i_hold) begin
            pc          <= pc + 32'd4;
            if_id_instr <= imem[fetch_addr];
        end
    end

    assign o_pc    = pc;
    assign o_instr = if_id_instr;

endmodule

// File: design/stage_decode.sv
`timescale 1ns/1ps

module stage_decode
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_step,
    input  word_t     i_instr,
    input  reg_addr_t i_dbg_reg,
    wb_bus.dst        wb,
    id_ex_bus.src     id_ex,
    output logic      o_hold_fetch,
    output word_t     o_dbg_reg_data
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    imm_t      imm;
    word_t     rs_data;
    word_t     rt_data;
    word_t     regs [32];

    alu_op_t   dec_alu_op;
    reg_addr_t dec_dst;
    logic      dec_alu_src;
    logic      dec_mem_read;
    logic      dec_mem_write;
    logic      dec_reg_write;
    logic      dec_halt;

    logic      load_use;
    logic      halt_seen;
    logic      bubble;

    assign opcode = i_instr[31:26];
    assign funct  = i_instr[5:0];
    assign rs     = i_instr[RS_LSB +: $bits(reg_addr_t)];
    assign rt     = i_instr[RT_LSB +: $bits(reg_addr_t)];
    assign rd     = i_instr[RD_LSB +: $bits(reg_addr_t)];
    assign imm    = i_instr[15:0];

    always_comb begin
        dec_alu_op    = ALU_ADD;
        dec_dst       = rt;
        dec_alu_src   = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_reg_write = 1'b0;
        dec_halt      = 1'b0;
        case (opcode)
            OPCODE_RTYPE: begin
                dec_dst       = rd;
                dec_reg_write = 1'b1;
                case (funct)
                    FUNCT_ADD: dec_alu_op = ALU_ADD;
                    FUNCT_SUB: dec_alu_op = ALU_SUB;
                    FUNCT_AND: dec_alu_op = ALU_AND;
                    FUNCT_OR:  dec_alu_op = ALU_OR;
                    FUNCT_SLT: dec_alu_op = ALU_SLT;
                    // Unknown funct, including the all-zero no-op
                    default:   dec_reg_write = 1'b0;
                endcase
            end
            OPCODE_ADDI: begin
                dec_alu_src   = 1'b1;
                dec_reg_write = 1'b1;
            end
            OPCODE_LW: begin
                dec_alu_src   = 1'b1;
                dec_mem_read  = 1'b1;
                dec_reg_write = 1'b1;
            end
            OPCODE_SW: begin
                dec_alu_src   = 1'b1;
                dec_mem_write = 1'b1;
            end
            OPCODE_HALT: dec_halt = 1'b1;
            default: ;
        endcase
    end

    function automatic word_t read_port(input reg_addr_t addr, input word_t stored,
                                        input logic wr_en, input reg_addr_t wr_addr,
                                        input word_t wr_data);
        if (addr == '0) begin
            return '0;
        end
        // Writeback in the same cycle wins over the array
        if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return stored;
    endfunction

    assign rs_data        = read_port(rs, regs[rs], wb.reg_write, wb.dst_reg, wb.data);
    assign rt_data        = read_port(rt, regs[rt], wb.reg_write, wb.dst_reg, wb.data);
    assign o_dbg_reg_data = regs[i_dbg_reg];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            foreach (regs[i]) begin
                regs[i] <= '0;
            end
        end else if (i_step && wb.reg_write && wb.dst_reg != '0) begin
            regs[wb.dst_reg] <= wb.data;
        end
    end

    // Load in EX feeding this instruction
    assign load_use     = id_ex.mem_read && (id_ex.rt == rs || id_ex.rt == rt);
    assign bubble       = load_use || halt_seen;
    assign o_hold_fetch = bubble || dec_halt;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            halt_seen <= 1'b0;
        end else if (i_step && dec_halt && !load_use) begin
            halt_seen <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            id_ex.rs_data   <= '0;
            id_ex.rt_data   <= '0;
            id_ex.imm_ext   <= '0;
            id_ex.rs        <= '0;
            id_ex.rt        <= '0;
            id_ex.dst_reg   <= '0;
            id_ex.alu_op    <= ALU_ADD;
            id_ex.alu_src   <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.halt      <= 1'b0;
        end else if (i_step) begin
            id_ex.rs_data   <= rs_data;
            id_ex.rt_data   <= rt_data;
            id_ex.imm_ext   <= {{16{imm[15]}}, imm};
            id_ex.rs        <= rs;
            id_ex.rt        <= rt;
            id_ex.dst_reg   <= dec_dst;
            id_ex.alu_op    <= dec_alu_op;
            id_ex.alu_src   <= dec_alu_src;
            id_ex.mem_read  <= dec_mem_read && !bubble;
            id_ex.mem_write <= dec_mem_write && !bubble;
            id_ex.reg_write <= dec_reg_write && !bubble;
            id_ex.halt      <= dec_halt && !bubble;
        end
    end

endmodule

// File: design/stage_execute.sv
`timescale 1ns/1ps

module stage_execute
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_step,
    id_ex_bus.dst   id_ex,
    wb_bus.dst      wb,
    ex_mem_bus.src  ex_mem
);

    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    word_t    op_a;
    word_t    fwd_b;
    word_t    op_b;
    word_t    alu_result;

    // Newer stage first, register 0 never forwarded
    function automatic fwd_sel_t pick_source(input reg_addr_t src,
                                             input logic mem_wr, input reg_addr_t mem_dst,
                                             input logic wb_wr, input reg_addr_t wb_dst);
        if (src == '0) begin
            return FWD_NONE;
        end
        if (mem_wr && mem_dst == src) begin
            return FWD_EXMEM;
        end
        if (wb_wr && wb_dst == src) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    function automatic word_t pick_value(input fwd_sel_t sel, input word_t id_val,
                                         input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_EXMEM: return mem_val;
            FWD_MEMWB: return wb_val;
            default:   return id_val;
        endcase
    endfunction

    assign sel_a = pick_source(id_ex.rs, ex_mem.reg_write, ex_mem.dst_reg,
                               wb.reg_write, wb.dst_reg);
    assign sel_b = pick_source(id_ex.rt, ex_mem.reg_write, ex_mem.dst_reg,
                               wb.reg_write, wb.dst_reg);

    assign op_a  = pick_value(sel_a, id_ex.rs_data, ex_mem.alu_result, wb.data);
    assign fwd_b = pick_value(sel_b, id_ex.rt_data, ex_mem.alu_result, wb.data);
    assign op_b  = id_ex.alu_src ? id_ex.imm_ext : fwd_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ex_mem.alu_result <= '0;
            ex_mem.store_data <= '0;
            ex_mem.dst_reg    <= '0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.reg_write  <= 1'b0;
            ex_mem.halt       <= 1'b0;
        end else if (i_step) begin
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= fwd_b;
            ex_mem.dst_reg    <= id_ex.dst_reg;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.halt       <= id_ex.halt;
        end
    end

endmodule

// File: design/stage_memory.sv
`timescale 1ns/1ps

module stage_memory
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_step,
    input  word_t   i_dbg_addr,
    ex_mem_bus.dst  ex_mem,
    wb_bus.src      wb,
    output word_t   o_dbg_data
);

    word_t      dmem [DMEM_DEPTH];
    dmem_addr_t mem_addr;
    dmem_addr_t dbg_addr;
    word_t      load_data;

    // Word-aligned accesses only
    assign mem_addr   = ex_mem.alu_result[9:2];
    assign dbg_addr   = i_dbg_addr[9:2];
    assign load_data  = dmem[mem_addr];
    assign o_dbg_data = dmem[dbg_addr];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            foreach (dmem[i]) begin
                dmem[i] <= '0;
            end
        end else if (i_step && ex_mem.mem_write) begin
            dmem[mem_addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wb.reg_write <= 1'b0;
            wb.dst_reg   <= '0;
            wb.data      <= '0;
            wb.halt      <= 1'b0;
        end else if (i_step) begin
            wb.reg_write <= ex_mem.reg_write;
            wb.dst_reg   <= ex_mem.dst_reg;
            wb.data      <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
            // Halt stays set until reset
            wb.halt      <= wb.halt || ex_mem.halt;
        end
    end

endmodule

// File: design/top_mips.sv
`timescale 1ns/1ps

module top_mips
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_step,
    input  imem_addr_t i_select_address_mem_instr,
    input  word_t      i_dato_mem_ins,
    input  logic       i_flag_write_mem_ins,
    input  reg_addr_t  i_select_address_register,
    input  word_t      i_select_mem_dir,
    output word_t      o_pc,
    output word_t      o_data_reg_file,
    output word_t      o_data_mem,
    output logic       o_mips_halt
);

    word_t if_id_instr;
    logic  hold_fetch;

    id_ex_bus  id_ex_if ();
    ex_mem_bus ex_mem_if ();
    wb_bus     wb_if ();

    stage_fetch module_fetch (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_step         (i_step),
        .i_hold         (hold_fetch),
        .i_imem_wr_en   (i_flag_write_mem_ins),
        .i_imem_wr_addr (i_select_address_mem_instr),
        .i_imem_wr_data (i_dato_mem_ins),
        .o_pc           (o_pc),
        .o_instr        (if_id_instr)
    );

    stage_decode module_decode (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_step         (i_step),
        .i_instr        (if_id_instr),
        .i_dbg_reg      (i_select_address_register),
        .wb             (wb_if.dst),
        .id_ex          (id_ex_if.src),
        .o_hold_fetch   (hold_fetch),
        .o_dbg_reg_data (o_data_reg_file)
    );

    stage_execute module_execute (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_step         (i_step),
        .id_ex          (id_ex_if.dst),
        .wb             (wb_if.dst),
        .ex_mem         (ex_mem_if.src)
    );

    stage_memory module_memory (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_step         (i_step),
        .i_dbg_addr     (i_select_mem_dir),
        .ex_mem         (ex_mem_if.dst),
        .wb             (wb_if.src),
        .o_dbg_data     (o_data_mem)
    );

    // MEM/WB halt bit held until reset
    assign o_mips_halt = wb_if.halt;

endmodule

// File: bench/top_mips_assertions.sv
`timescale 1ns/1ps

module top_mips_assertions
    import mips_isa_pkg::*;
(
    input logic  i_clk,
    input logic  i_rst,
    input word_t i_pc,
    input logic  i_halt
);

    int unsigned fail_count = 0;

    // State right after a reset cycle
    reset_clears: assert property (@(posedge i_clk) i_rst |=> (i_pc == '0 && !i_halt))
        else begin
            fail_count++;
            $error("PC or halt not cleared one cycle after reset");
        end

    halt_sticky: assert property (@(posedge i_clk) disable iff (i_rst) i_halt |=> i_halt)
        else begin
            fail_count++;
            $error("Halt output dropped without reset");
        end

    // Fetch frozen once halted
    pc_frozen: assert property (@(posedge i_clk) disable iff (i_rst) i_halt |=> $stable(i_pc))
        else begin
            fail_count++;
            $error("PC moved while halted");
        end

endmodule

// File: bench/top_mips_tb.sv
`timescale 1ns/1ps

module top_mips_tb
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
();

    localparam int PROG_LEN        = 16;
    localparam int N_CHECKS        = 15;
    localparam int HALT_INDEX      = 14;
    localparam int POST_HALT_STEPS = 4;
    localparam int CYCLE_LIMIT     = 4 * (PROG_LEN + 10) + 50;

    typedef struct packed {
        logic  is_mem;
        word_t addr;
        word_t expected;
    } check_t;

    logic       i_clk = 1'b0;
    logic       i_rst;
    logic       i_step;
    imem_addr_t i_select_address_mem_instr;
    word_t      i_dato_mem_ins;
    logic       i_flag_write_mem_ins;
    reg_addr_t  i_select_address_register;
    word_t      i_select_mem_dir;
    word_t      o_pc;
    word_t      o_data_reg_file;
    word_t      o_data_mem;
    logic       o_mips_halt;

    word_t      program_words [PROG_LEN];
    check_t     checks [N_CHECKS];
    int         cycle_count = 0;

    top_mips i_top_mips (
        .i_clk                      (i_clk),
        .i_rst                      (i_rst),
        .i_step                     (i_step),
        .i_select_address_mem_instr (i_select_address_mem_instr),
        .i_dato_mem_ins             (i_dato_mem_ins),
        .i_flag_write_mem_ins       (i_flag_write_mem_ins),
        .i_select_address_register  (i_select_address_register),
        .i_select_mem_dir           (i_select_mem_dir),
        .o_pc                       (o_pc),
        .o_data_reg_file            (o_data_reg_file),
        .o_data_mem                 (o_data_mem),
        .o_mips_halt                (o_mips_halt)
    );

    bind top_mips top_mips_assertions top_mips_checks (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_pc   (o_pc),
        .i_halt (o_mips_halt)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the halt output never arrived", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "Cycle limit reached");
        end
    end

    always @(negedge i_clk) begin
        if (i_top_mips.top_mips_checks.fail_count != 0) begin
            $display("A bound assertion on reset, halt or PC failed at %0t ns", $time);
            $display("Simulation failed");
            $fatal(1, "Assertion failure");
        end
    end

    function automatic word_t r_type_word(input funct_t funct, input reg_addr_t rd,
                                          input reg_addr_t rs, input reg_addr_t rt);
        return {OPCODE_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t i_type_word(input opcode_t op, input reg_addr_t rt,
                                          input reg_addr_t rs, input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t sign_extend(input imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t signed_less(input word_t a, input word_t b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    initial begin
        word_t e_r1, e_r2, e_r3, e_r4, e_r5, e_r6, e_r7;
        word_t e_r8, e_r9, e_r10, e_r11, e_r12;

        i_rst                      = 1'b1;
        i_step                     = 1'b0;
        i_select_address_mem_instr = '0;
        i_dato_mem_ins             = '0;
        i_flag_write_mem_ins       = 1'b0;
        i_select_address_register  = '0;
        i_select_mem_dir           = '0;

        // Dependent ALU chain
        program_words[0]  = i_type_word(OPCODE_ADDI, 5'd1, 5'd0, 16'd5);
        program_words[1]  = i_type_word(OPCODE_ADDI, 5'd2, 5'd1, 16'hFFFD);  // minus 3
        program_words[2]  = r_type_word(FUNCT_ADD, 5'd3, 5'd1, 5'd2);
        program_words[3]  = r_type_word(FUNCT_SUB, 5'd4, 5'd3, 5'd1);
        program_words[4]  = r_type_word(FUNCT_AND, 5'd5, 5'd4, 5'd3);
        program_words[5]  = r_type_word(FUNCT_OR, 5'd6, 5'd5, 5'd1);
        program_words[6]  = r_type_word(FUNCT_SLT, 5'd7, 5'd4, 5'd6);
        program_words[7]  = i_type_word(OPCODE_ADDI, 5'd8, 5'd0, 16'hFFFC);  // minus 4
        program_words[8]  = r_type_word(FUNCT_SLT, 5'd9, 5'd8, 5'd1);
        program_words[9]  = r_type_word(FUNCT_SUB, 5'd12, 5'd2, 5'd1);
        // Store, load back, then a use right behind the load
        program_words[10] = i_type_word(OPCODE_SW, 5'd12, 5'd0, 16'd8);
        program_words[11] = i_type_word(OPCODE_LW, 5'd10, 5'd0, 16'd8);
        program_words[12] = r_type_word(FUNCT_ADD, 5'd11, 5'd10, 5'd1);
        program_words[13] = i_type_word(OPCODE_ADDI, 5'd0, 5'd0, 16'd9);
        program_words[HALT_INDEX] = {OPCODE_HALT, 26'd0};
        program_words[15] = i_type_word(OPCODE_ADDI, 5'd13, 5'd0, 16'd1);

        e_r1  = 32'd0 + sign_extend(16'd5);
        e_r2  = e_r1 + sign_extend(16'hFFFD);
        e_r3  = e_r1 + e_r2;
        e_r4  = e_r3 - e_r1;
        e_r5  = e_r4 & e_r3;
        e_r6  = e_r5 | e_r1;
        e_r7  = signed_less(e_r4, e_r6);
        e_r8  = 32'd0 + sign_extend(16'hFFFC);
        e_r9  = signed_less(e_r8, e_r1);
        e_r12 = e_r2 - e_r1;
        e_r10 = e_r12;
        e_r11 = e_r10 + e_r1;

        checks[0]  = '{1'b0, 32'd1, e_r1};
        checks[1]  = '{1'b0, 32'd2, e_r2};
        checks[2]  = '{1'b0, 32'd3, e_r3};
        checks[3]  = '{1'b0, 32'd4, e_r4};
        checks[4]  = '{1'b0, 32'd5, e_r5};
        checks[5]  = '{1'b0, 32'd6, e_r6};
        checks[6]  = '{1'b0, 32'd7, e_r7};
        checks[7]  = '{1'b0, 32'd8, e_r8};
        checks[8]  = '{1'b0, 32'd9, e_r9};
        checks[9]  = '{1'b0, 32'd12, e_r12};
        checks[10] = '{1'b1, 32'd8, e_r12};
        checks[11] = '{1'b0, 32'd10, e_r10};
        checks[12] = '{1'b0, 32'd11, e_r11};
        checks[13] = '{1'b0, 32'd0, 32'd0};
        checks[14] = '{1'b0, 32'd13, 32'd0};

        repeat (10) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        i_flag_write_mem_ins = 1'b1;
        for (int k = 0; k < PROG_LEN; k++) begin
            i_select_address_mem_instr = imem_addr_t'(k);
            i_dato_mem_ins             = program_words[k];
            next_cycle();
        end
        i_flag_write_mem_ins = 1'b0;

        check_value(o_pc, 32'd0, "PC before run");
        check_value({31'd0, o_mips_halt}, 32'd0, "halt before run");
        for (int r = 1; r <= 3; r++) begin
            i_select_address_register = 5'(r);
            next_cycle();
            check_value(o_data_reg_file, 32'd0, $sformatf("register r%0d before run", r));
        end

        i_step = 1'b1;
        while (!o_mips_halt) begin
            next_cycle();
        end
        // Keep stepping so halt and the frozen fetch are seen to hold
        repeat (POST_HALT_STEPS) begin
            next_cycle();
        end
        i_step = 1'b0;
        check_value({31'd0, o_mips_halt}, 32'd1, "halt after run");
        check_value(o_pc, 32'(4 * (HALT_INDEX + 1)), "PC after halt");

        for (int k = 0; k < N_CHECKS; k++) begin
            i_select_address_register = checks[k].addr[4:0];
            i_select_mem_dir          = checks[k].addr;
            next_cycle();
            if (checks[k].is_mem) begin
                check_value(o_data_mem, checks[k].expected,
                            $sformatf("memory byte address %0d", checks[k].addr));
            end else begin
                check_value(o_data_reg_file, checks[k].expected,
                            $sformatf("register r%0d", checks[k].addr));
            end
        end

        if (i_top_mips.top_mips_checks.fail_count != 0) begin
            $display("A bound assertion failed during the run");
            $display("Simulation failed");
            $fatal(1, "Assertion failure");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: vlog.f
design/mips_isa_pkg.sv
design/mips_core_pkg.sv
design/mips_stage_if.sv
design/stage_fetch.sv
design/stage_decode.sv
design/stage_execute.sv
design/stage_memory.sv
design/top_mips.sv
bench/top_mips_assertions.sv
bench/top_mips_tb.sv

// File: Makefile
SOURCES := $(wildcard design/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtop_mips_tb: vlog.f $(SOURCES)
	verilator --binary --timing --assert --top-module top_mips_tb -f vlog.f -o Vtop_mips_tb

run: obj_dir/Vtop_mips_tb
	-./obj_dir/Vtop_mips_tb +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
